// File: filelist.f
logic/arbiter_pkg.sv
logic/rr_arbiter.sv
logic/aer_arbiter.sv
logic/event_encoder.sv
logic/aer_top.sv
verification/aer_top_tb.sv

// File: logic/aer_arbiter.sv
// Row-then-column AER arbitration FSM that offers the selected pixel to the encoder and acks it
`timescale 1ns/10ps
`default_nettype none

module aer_arbiter
    import arbiter_pkg::*;
(
    input  logic                      clk_i,              // Clock
    input  logic                      reset_i,            // Async reset, active high
    input  logic                      enable_i,           // Arbitration enable
    input  pix_req_t [COLS-1:0]       req_i [ROWS-1:0],   // Pixel request levels by row
    output logic [ROWS-1:0][COLS-1:0] gnt_o,              // Pixel acknowledge
    output logic                      sel_valid_o,        // Selection offered
    input  logic                      sel_ready_i,        // Encoder can take it
    output row_addr_t                 sel_row_o,          // Selected row
    output col_addr_t                 sel_col_o,          // Selected column
    output pix_req_t                  sel_pol_o           // Selected pixel's request bits
);

    typedef enum logic [1:0]
    {
        IDLE      = 2'b00,                                // Arbitration stopped
        ROW_GRANT = 2'b01,                                // Pick and latch a row
        COL_GRANT = 2'b10                                 // Serve columns of latched row
    } arb_state_t;

    arb_state_t      state_q, state_d;                    // FSM state

    logic [ROWS-1:0] row_active;                          // Rows with any request
    logic [ROWS-1:0] row_gnt;                             // One-hot row winner
    row_addr_t       row_idx;                             // Row winner index
    row_addr_t       row_q;                               // Latched row
    logic            row_adv;                             // Latch row and move row pointer

    logic [COLS-1:0] col_live;                            // Live column requests of row_q
    logic [COLS-1:0] col_req;                             // Column requests seen by arbiter
    logic [COLS-1:0] col_gnt;                             // One-hot column winner
    col_addr_t       col_idx;                             // Column winner index

    logic            hold_q;                              // Stalled offer being held
    logic [COLS-1:0] hold_req_q;                          // Column requests frozen at stall
    logic            xfer;                                // Selection handshake done

    // Row is active if any pixel in it requests either polarity
    always_comb
    begin
        for (int r = 0; r < ROWS; r++)
        begin
            row_active[r] = |req_i[r];
        end
    end

    // Column requests of the latched row
    always_comb
    begin
        for (int c = 0; c < COLS; c++)
        begin
            col_live[c] = |req_i[row_q][c];
        end
    end

    // Freeze the column view during a stall so the offer cannot move
    assign col_req = hold_q ? hold_req_q : col_live;

    // Next state and offer
    always_comb
    begin
        state_d     = state_q;
        row_adv     = 1'b0;
        sel_valid_o = 1'b0;
        case (state_q)
            IDLE:
            begin
                if (enable_i)
                begin
                    state_d = ROW_GRANT;
                end
            end
            ROW_GRANT:
            begin
                if (!enable_i)
                begin
                    state_d = IDLE;
                end
                else if (|row_gnt)
                begin
                    row_adv = 1'b1;                       // Latch winner and move pointer past it
                    state_d = COL_GRANT;
                end
            end
            COL_GRANT:
            begin
                if (!enable_i)
                begin
                    state_d = IDLE;
                end
                else if (|col_gnt)
                begin
                    sel_valid_o = 1'b1;                   // Offer until accepted
                end
                else
                begin
                    state_d = ROW_GRANT;                  // Row drained, rearbitrate
                end
            end
            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

    assign xfer      = sel_valid_o && sel_ready_i;
    assign sel_row_o = row_q;
    assign sel_col_o = col_idx;
    assign sel_pol_o = req_i[row_q][col_idx];

    // Ack only the pixel at the row/column crossing in the transfer cycle
    always_comb
    begin
        gnt_o                  = '0;
        gnt_o[row_q][col_idx]  = xfer;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= IDLE;
            row_q   <= '0;
            hold_q  <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            hold_q  <= sel_valid_o && !sel_ready_i;       // Set while the encoder stalls
            if (row_adv)
            begin
                row_q <= row_idx;
            end
        end
    end

    // Snapshot of column requests taken at each stalled cycle
    always_ff @(posedge clk_i)
    begin
        if (sel_valid_o && !sel_ready_i)
        begin
            hold_req_q <= col_req;
        end
    end

    rr_arbiter #(
        .N         (ROWS)
    ) u_row_rr (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (row_active),
        .advance_i (row_adv),
        .gnt_o     (row_gnt),
        .idx_o     (row_idx)
    );

    rr_arbiter #(
        .N         (COLS)
    ) u_col_rr (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (col_req),
        .advance_i (xfer),                                // Column pointer moves on transfer
        .gnt_o     (col_gnt),
        .idx_o     (col_idx)
    );

    // At most one pixel acked per cycle and only a pixel that still requests
    a_gnt_single: assert property (@(posedge clk_i) disable iff (reset_i)
        (|gnt_o) |-> ($onehot(gnt_o) && (sel_pol_o != '0)))
        else $error("Grant to more than one pixel or to an idle pixel");

    // A stalled offer holds until taken unless arbitration is switched off
    a_sel_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (sel_valid_o && !sel_ready_i) |=> (!enable_i ||
        (sel_valid_o && $stable(sel_row_o) && $stable(sel_col_o) && $stable(sel_pol_o))))
        else $error("Selection changed while stalled");

endmodule : aer_arbiter

`default_nettype wire

// File: logic/aer_top.sv
// AER readout top, joins the pixel arbiter to the event encoder and the event port
`timescale 1ns/10ps
`default_nettype none

module aer_top
    import arbiter_pkg::*;
(
    input  logic                      clk_i,              // Clock
    input  logic                      reset_i,            // Async reset, active high
    input  logic                      enable_i,           // Arbitration enable
    input  pix_req_t [COLS-1:0]       req_i [ROWS-1:0],   // Pixel request levels
    output logic [ROWS-1:0][COLS-1:0] gnt_o,              // Pixel acknowledge
    output event_word_t               evt_data_o,         // Event word
    output logic                      evt_valid_o,        // Event valid
    input  logic                      evt_ready_i         // Event ready
);

    logic      sel_valid;                                 // Arbiter offer
    logic      sel_ready;                                 // Encoder accept
    row_addr_t sel_row;                                   // Offered row
    col_addr_t sel_col;                                   // Offered column
    pix_req_t  sel_pol;                                   // Offered request bits

    aer_arbiter u_arbiter (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .enable_i    (enable_i),
        .req_i       (req_i),
        .gnt_o       (gnt_o),
        .sel_valid_o (sel_valid),
        .sel_ready_i (sel_ready),
        .sel_row_o   (sel_row),
        .sel_col_o   (sel_col),
        .sel_pol_o   (sel_pol)
    );

    event_encoder u_encoder (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .sel_valid_i (sel_valid),
        .sel_ready_o (sel_ready),
        .sel_row_i   (sel_row),
        .sel_col_i   (sel_col),
        .sel_pol_i   (sel_pol),
        .evt_data_o  (evt_data_o),
        .evt_valid_o (evt_valid_o),
        .evt_ready_i (evt_ready_i)
    );

endmodule : aer_top

`default_nettype wire

// File: logic/arbiter_pkg.sv
// Array sizes, field widths and vector types shared by the AER readout RTL and its testbench
`default_nettype none

package arbiter_pkg;

    // Pixel array geometry
    localparam int ROWS     = 4;                    // Number of pixel rows
    localparam int COLS     = 4;                    // Number of pixel columns
    localparam int POLARITY = 2;                    // Request bits per pixel, bit 0 ON and bit 1 OFF

    // Address field widths
    localparam int X_WIDTH  = 2;                    // Row address width
    localparam int Y_WIDTH  = 2;                    // Column address width

    // Wallclock width
    localparam int TS_SIZE  = 16;                   // Free-running timestamp width

    // Event word layout, MSB first: row, column, timestamp, polarity
    localparam int WIDTH    = X_WIDTH + Y_WIDTH + TS_SIZE + 1;   // 21 bits in total

    // Row address
    typedef logic [X_WIDTH-1:0]  row_addr_t;

    // Column address
    typedef logic [Y_WIDTH-1:0]  col_addr_t;

    // One pixel's request level
    typedef logic [POLARITY-1:0] pix_req_t;

    // Wallclock sample
    typedef logic [TS_SIZE-1:0]  timestamp_t;

    // Packed output event
    typedef logic [WIDTH-1:0]    event_word_t;

endpackage : arbiter_pkg

`default_nettype wire

// File: logic/event_encoder.sv
// Event encoder with wallclock, polarity pick and a one-word valid/ready output register
`timescale 1ns/10ps
`default_nettype none

module event_encoder
    import arbiter_pkg::*;
(
    input  logic        clk_i,                            // Clock
    input  logic        reset_i,                          // Async reset, active high
    input  logic        sel_valid_i,                      // Selection offered
    output logic        sel_ready_o,                      // Register free this cycle
    input  row_addr_t   sel_row_i,                        // Selected row
    input  col_addr_t   sel_col_i,                        // Selected column
    input  pix_req_t    sel_pol_i,                        // Selected request bits
    output event_word_t evt_data_o,                       // Packed event
    output logic        evt_valid_o,                      // Event present
    input  logic        evt_ready_i                       // Sink takes the event
);

    timestamp_t wallclock_q;                              // Free-running time base
    logic       pol_bit;                                  // Encoded polarity
    logic       load;                                     // Selection accepted

    // Wraps silently at the top
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            wallclock_q <= '0;
        end
        else
        begin
            wallclock_q <= wallclock_q + 1'b1;
        end
    end

    // ON wins when both bits are raised
    always_comb
    begin
        if (sel_pol_i[0])
        begin
            pol_bit = 1'b1;                               // ON event
        end
        else
        begin
            pol_bit = 1'b0;                               // OFF event
        end
    end

    // Free when empty or draining this cycle
    assign sel_ready_o = !evt_valid_o || evt_ready_i;
    assign load        = sel_valid_i && sel_ready_o;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            evt_valid_o <= 1'b0;
        end
        else if (load)
        begin
            evt_valid_o <= 1'b1;
        end
        else if (evt_ready_i)
        begin
            evt_valid_o <= 1'b0;                          // Word consumed
        end
    end

    // Event word captured on each accepted selection
    always_ff @(posedge clk_i)
    begin
        if (load)
        begin
            evt_data_o <= {sel_row_i, sel_col_i, wallclock_q, pol_bit};
        end
    end

    // Word must not change while the sink back-pressures
    a_evt_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (evt_valid_o && !evt_ready_i) |=> (evt_valid_o && $stable(evt_data_o)))
        else $error("Event word changed under back-pressure");

endmodule : event_encoder

`default_nettype wire

// File: logic/rr_arbiter.sv
// Round-robin arbiter with rotating priority, one instance each for rows and for columns
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter #(
    parameter int N = 4                                   // Number of requesters
) (
    input  logic                                clk_i,     // Clock
    input  logic                                reset_i,   // Async reset, active high
    input  logic [N-1:0]                        req_i,     // Request vector
    input  logic                                advance_i, // Store current winner as last granted
    output logic [N-1:0]                        gnt_o,     // One-hot grant
    output logic [((N > 1) ? $clog2(N) : 1)-1:0] idx_o     // Index of the grant
);

    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;       // Index width

    logic [IDX_W-1:0] last_q;                             // Last granted index
    logic             found;                              // Winner already picked in the scan
    int unsigned      cand;                               // Candidate index in the scan

    // Scan from the slot after last_q, wrapping round to 0
    always_comb
    begin
        gnt_o = '0;
        idx_o = '0;
        found = 1'b0;
        cand  = 0;
        for (int i = 1; i <= N; i++)
        begin
            cand = (int'(last_q) + i) % N;                // Next slot in rotation
            if (!found && req_i[cand])
            begin
                found        = 1'b1;                      // First requester wins
                gnt_o[cand]  = 1'b1;
                idx_o        = IDX_W'(cand);
            end
        end
    end

    // Pointer starts at the top so index 0 has first priority
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            last_q <= IDX_W'(N - 1);
        end
        else if (advance_i && found)
        begin
            last_q <= idx_o;                              // Winner drops to lowest priority
        end
    end

    // Never more than one requester granted
    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o))
        else $error("rr_arbiter grant not one-hot");

endmodule : rr_arbiter

`default_nettype wire

// File: verification/aer_top_tb.sv
// Table-driven testbench for the AER readout that models the pixel array and checks each event word
`timescale 1ns/10ps
`default_nettype none

module aer_top_tb
    import arbiter_pkg::*;
();

    localparam int CLK_PERIOD    = 20;                    // ns
    localparam int RESET_CYCLES  = 10;
    localparam int NUM_TESTS     = 7;                     // Entries in the table
    localparam int NUM_EVENTS    = 21;                    // Expected events over all entries
    localparam int QUIET_CYCLES  = 20;                    // Enable held low before raising it
    localparam int SETTLE_CYCLES = 6;                     // Watch for stray events after a test
    localparam int TEST_BOUND    = 40;                    // Cycle overhead allowed per test
    localparam int EVENT_BOUND   = 40;                    // Cycles allowed per event including stalls
    localparam int CYCLE_LIMIT   = RESET_CYCLES + NUM_TESTS * TEST_BOUND
                                 + NUM_EVENTS * EVENT_BOUND;

    logic                      clk;
    logic                      reset;
    logic                      enable;
    pix_req_t [COLS-1:0]       pix_req [ROWS-1:0];        // Pixel array model
    logic [ROWS-1:0][COLS-1:0] gnt;
    event_word_t               evt_data;
    logic                      evt_valid;
    logic                      evt_ready;

    // Stimulus and expected values
    string                          test_name [NUM_TESTS];
    logic [POLARITY*ROWS*COLS-1:0]  req_pat   [NUM_TESTS]; // Pixel (r,c) at slot r*COLS+c
    bit                             late_en   [NUM_TESTS]; // Enable held low at start
    bit                             stall_en  [NUM_TESTS]; // Random back-pressure
    int                             exp_first [NUM_TESTS]; // First entry in exp_evt
    int                             exp_count [NUM_TESTS];
    logic [X_WIDTH+Y_WIDTH:0]       exp_evt   [NUM_EVENTS]; // {row, col, pol} in order
    int                             n_tests;
    int                             n_events;

    logic [31:0] rng_state;                               // xorshift state
    int          value_errors;
    int          protocol_errors;
    int          cycle_cnt;
    int          got;                                     // Events seen in current test
    int          grants;                                  // Grant pulses in current test
    timestamp_t  prev_ts;
    bit          hold_pending;                            // Word was stalled last cycle
    event_word_t held_word;

    aer_top u_aer_top (
        .clk_i       (clk),
        .reset_i     (reset),
        .enable_i    (enable),
        .req_i       (pix_req),
        .gnt_o       (gnt),
        .evt_data_o  (evt_data),
        .evt_valid_o (evt_valid),
        .evt_ready_i (evt_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Ends the run if the expected events never all arrive
    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles, not all expected events arrived", cycle_cnt);
            report_counts();
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic bit at_most_one(input logic [ROWS*COLS-1:0] v);
        return (v & (v - 1'b1)) == '0;                    // Clears lowest set bit
    endfunction

    task automatic report_counts();
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    endtask

    task automatic new_test(input string name, input bit late, input bit stall);
        test_name[n_tests] = name;
        req_pat[n_tests]   = '0;
        late_en[n_tests]   = late;
        stall_en[n_tests]  = stall;
        exp_first[n_tests] = n_events;
        exp_count[n_tests] = 0;
        n_tests++;
    endtask

    // Raises one pixel in the current test and appends its event in expected order
    task automatic add_event(input int r, input int c, input pix_req_t bits, input logic pol);
        int t;
        t = n_tests - 1;
        req_pat[t][POLARITY * (r * COLS + c) +: POLARITY] = bits;
        exp_evt[n_events] = {row_addr_t'(r), col_addr_t'(c), pol};
        exp_count[t]++;
        n_events++;
    endtask

    // Pointers carry over between entries and both start at 3 after reset
    task automatic load_table();
        new_test("single_on", 1'b0, 1'b0);
        add_event(1, 2, 2'b01, 1'b1);
        new_test("single_off", 1'b0, 1'b0);
        add_event(2, 1, 2'b10, 1'b0);
        new_test("both_bits", 1'b0, 1'b0);
        add_event(0, 3, 2'b11, 1'b1);                     // ON wins over OFF
        new_test("full_row", 1'b0, 1'b0);                 // Column pointer at 3 gives ascending order
        add_event(2, 0, 2'b01, 1'b1);
        add_event(2, 1, 2'b10, 1'b0);
        add_event(2, 2, 2'b11, 1'b1);
        add_event(2, 3, 2'b01, 1'b1);
        new_test("multi_row", 1'b0, 1'b0);                // Row pointer at 2 so rows go 3 then 0 then 1
        add_event(3, 1, 2'b01, 1'b1);
        add_event(3, 2, 2'b10, 1'b0);
        add_event(0, 3, 2'b01, 1'b1);                     // Column pointer at 2 wraps round
        add_event(0, 0, 2'b10, 1'b0);
        add_event(1, 1, 2'b11, 1'b1);
        new_test("random_stall", 1'b0, 1'b1);             // Row and column pointers both at 1
        add_event(2, 2, 2'b10, 1'b0);
        add_event(2, 3, 2'b11, 1'b1);
        add_event(2, 1, 2'b01, 1'b1);
        add_event(3, 0, 2'b10, 1'b0);
        add_event(0, 2, 2'b11, 1'b1);
        add_event(0, 0, 2'b01, 1'b1);
        new_test("enable_late", 1'b1, 1'b0);              // Row and column pointers both at 0
        add_event(1, 3, 2'b10, 1'b0);
        add_event(1, 0, 2'b01, 1'b1);
        add_event(2, 2, 2'b11, 1'b1);
    endtask

    task automatic check_word(input int t, input event_word_t d);
        logic [X_WIDTH+Y_WIDTH:0] exp;
        logic [X_WIDTH+Y_WIDTH:0] act;
        timestamp_t               ts;
        act = {d[WIDTH-1 -: X_WIDTH+Y_WIDTH], d[0]};      // Row, column, polarity
        ts  = d[TS_SIZE:1];
        assert (got < exp_count[t])
        else
        begin
            protocol_errors++;
            $display("%s: extra event word %0h after all expected events", test_name[t], d);
        end
        if (got < exp_count[t])
        begin
            exp = exp_evt[exp_first[t] + got];
            assert (act == exp)
            else
            begin
                value_errors++;
                $display("error %s: event %0d expected r%0d c%0d p%0d actual r%0d c%0d p%0d",
                         test_name[t], got, exp[4:3], exp[2:1], exp[0],
                         act[4:3], act[2:1], act[0]);
            end
            if (got > 0)
            begin
                assert (ts > prev_ts)
                else
                begin
                    value_errors++;
                    $display("error %s: timestamp of event %0d expected above %0h actual %0h",
                             test_name[t], got, prev_ts, ts);
                end
            end
            got++;
        end
        prev_ts = ts;
    endtask

    // Samples at the falling edge and drives just after the rising edge
    task automatic step_cycle(input int t);
        logic [ROWS-1:0][COLS-1:0] g;
        event_word_t               d;
        logic                      v;
        logic                      rdy;
        @(negedge clk);
        g   = gnt;
        v   = evt_valid;
        d   = evt_data;
        rdy = evt_ready;
        assert (at_most_one(g))
        else
        begin
            protocol_errors++;
            $display("%s: more than one pixel granted in one cycle", test_name[t]);
        end
        if (!enable)
        begin
            assert (g == '0 && !v)
            else
            begin
                protocol_errors++;
                $display("%s: grant or event while arbitration is disabled", test_name[t]);
            end
        end
        if (hold_pending)
        begin
            assert (v && d == held_word)
            else
            begin
                protocol_errors++;
                $display("%s: event word changed or dropped under back-pressure", test_name[t]);
            end
        end
        hold_pending = v && !rdy;
        held_word    = d;
        if (v && rdy)
        begin
            check_word(t, d);                             // Transfers at the next rising edge
        end
        @(posedge clk);
        #1;
        for (int r = 0; r < ROWS; r++)
        begin
            for (int c = 0; c < COLS; c++)
            begin
                if (g[r][c])
                begin
                    grants++;
                    assert (pix_req[r][c] != '0)
                    else
                    begin
                        protocol_errors++;
                        $display("%s: grant to idle pixel %0d,%0d", test_name[t], r, c);
                    end
                    pix_req[r][c] = '0;                   // Pixel drops its request on grant
                end
            end
        end
        if (stall_en[t])
        begin
            rng_state = xorshift(rng_state);
            evt_ready = rng_state[3];
        end
    endtask

    task automatic run_test(input int t);
        @(posedge clk);
        #1;
        got    = 0;
        grants = 0;
        for (int r = 0; r < ROWS; r++)
        begin
            for (int c = 0; c < COLS; c++)
            begin
                pix_req[r][c] = req_pat[t][POLARITY * (r * COLS + c) +: POLARITY];
            end
        end
        enable    = !late_en[t];
        evt_ready = 1'b1;
        if (late_en[t])
        begin
            repeat (QUIET_CYCLES) step_cycle(t);
            enable = 1'b1;                                // Pending events may now flow
        end
        while (got < exp_count[t])
        begin
            step_cycle(t);
        end
        repeat (SETTLE_CYCLES) step_cycle(t);
        assert (grants == exp_count[t])
        else
        begin
            value_errors++;
            $display("error %s: grant count expected %0d actual %0d",
                     test_name[t], exp_count[t], grants);
        end
        for (int r = 0; r < ROWS; r++)
        begin
            for (int c = 0; c < COLS; c++)
            begin
                assert (pix_req[r][c] == '0)
                else
                begin
                    protocol_errors++;
                    $display("%s: pixel %0d,%0d never granted", test_name[t], r, c);
                end
            end
        end
    endtask

    initial
    begin
        clk       = 1'b0;
        reset     = 1'b1;
        enable    = 1'b0;
        evt_ready = 1'b1;
        for (int r = 0; r < ROWS; r++)
        begin
            pix_req[r] = '0;
        end
        rng_state       = 32'h2aec43db;
        value_errors    = 0;
        protocol_errors = 0;
        cycle_cnt       = 0;
        n_tests         = 0;
        n_events        = 0;
        hold_pending    = 1'b0;
        held_word       = '0;
        prev_ts         = '0;
        load_table();
        assert (n_tests == NUM_TESTS && n_events == NUM_EVENTS)
        else
        begin
            protocol_errors++;
            $display("Stimulus table size does not match its declared length");
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset  = 1'b0;
        enable = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            run_test(t);
        end
        report_counts();
        if (value_errors + protocol_errors == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : aer_top_tb

`default_nettype wire
